// ==== common/frame_pkg.sv ====
package frame_pkg;

        // wide enough for item indices and for the running byte number
        localparam int INDEX_W = 8;

        // frame sections in the order they go out on the wire
        typedef enum logic [2:0] {
                SEC_SCORE,
                SEC_SHIP,
                SEC_AST_POS,
                SEC_AST_OPCODE,
                SEC_SHOT_POS,
                SEC_SHOT_OPCODE,
                SEC_SPECIAL,
                SEC_FOOTER
        } section_t;

        // sequencer states; the section is tracked in its own register
        typedef enum logic [2:0] {
                ST_IDLE,
                ST_CLEAR,
                ST_START,
                ST_WAIT,
                ST_ADVANCE
        } state_t;

endpackage

// ==== common/frame_count_if.sv ====
`timescale 1ns/1ps

interface frame_count_if;
        import frame_pkg::*;

        logic                 clear;
        logic                 advance;
        section_t             section;
        logic                 item_last;
        logic [INDEX_W-1:0]   item_index;

        modport sequencer (
                output clear,
                output advance,
                output section,
                input  item_last
        );

        modport counters (
                input  clear,
                input  advance,
                input  section,
                output item_last,
                output item_index
        );

endinterface

// ==== src/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer (
        input  logic clock,
        input  logic reset,
        input  logic send,
        input  logic tx_done,
        frame_count_if.sequencer count,
        output logic start,
        output logic clear,
        output logic frame_done
);
        import frame_pkg::*;

        state_t   state;
        state_t   state_next;
        section_t section;
        logic     frame_end;

        // footer's last item has gone out
        assign frame_end = (state == ST_ADVANCE) && count.item_last &&
                           (section == SEC_FOOTER);

        function automatic section_t next_section(input section_t sec);
                section_t nxt;
                case (sec)
                        SEC_SCORE:       nxt = SEC_SHIP;
                        SEC_SHIP:        nxt = SEC_AST_POS;
                        SEC_AST_POS:     nxt = SEC_AST_OPCODE;
                        SEC_AST_OPCODE:  nxt = SEC_SHOT_POS;
                        SEC_SHOT_POS:    nxt = SEC_SHOT_OPCODE;
                        SEC_SHOT_OPCODE: nxt = SEC_SPECIAL;
                        SEC_SPECIAL:     nxt = SEC_FOOTER;
                        default:         nxt = SEC_FOOTER;
                endcase
                return nxt;
        endfunction

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        state <= ST_IDLE;
                end else begin
                        state <= state_next;
                end
        end

        always_comb begin
                state_next = state;
                case (state)
                        ST_IDLE: begin
                                if (send) begin
                                        state_next = ST_CLEAR;
                                end
                        end
                        ST_CLEAR:   state_next = ST_START;
                        ST_START:   state_next = ST_WAIT;
                        ST_WAIT: begin
                                if (tx_done) begin
                                        state_next = ST_ADVANCE;
                                end
                        end
                        ST_ADVANCE: state_next = frame_end ? ST_IDLE : ST_START;
                        default:    state_next = ST_IDLE;
                endcase
        end

        // counters have not moved yet in ST_ADVANCE, so item_last still
        // refers to the byte that just finished
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        section    <= SEC_SCORE;
                        frame_done <= 1'b0;
                end else begin
                        frame_done <= frame_end;
                        if (state == ST_CLEAR) begin
                                section <= SEC_SCORE;
                        end else if (state == ST_ADVANCE && count.item_last &&
                                     section != SEC_FOOTER) begin
                                section <= next_section(section);
                        end
                end
        end

        assign start         = (state == ST_START);
        assign clear         = (state == ST_CLEAR);
        assign count.clear   = clear;
        assign count.advance = (state == ST_ADVANCE);
        assign count.section = section;

endmodule

// ==== src/section_counters.sv ====
`timescale 1ns/1ps

module section_counters #(
        parameter int N_ASTEROIDS    = 4,
        parameter int N_SHOTS        = 3,
        parameter int N_OPCODE_BYTES = 2,
        parameter int N_FOOTER       = 2
) (
        input  logic clock,
        input  logic reset,
        frame_count_if.counters count
);
        import frame_pkg::*;

        localparam logic [INDEX_W-1:0] AST_LAST    = INDEX_W'(N_ASTEROIDS - 1);
        localparam logic [INDEX_W-1:0] SHOT_LAST   = INDEX_W'(N_SHOTS - 1);
        localparam logic [INDEX_W-1:0] OPCODE_LAST = INDEX_W'(N_OPCODE_BYTES - 1);
        localparam logic [INDEX_W-1:0] FOOTER_LAST = INDEX_W'(N_FOOTER - 1);

        logic [INDEX_W-1:0] ast_count;
        logic [INDEX_W-1:0] shot_count;
        logic [INDEX_W-1:0] opcode_count;
        logic [INDEX_W-1:0] footer_count;

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        ast_count    <= '0;
                        shot_count   <= '0;
                        opcode_count <= '0;
                        footer_count <= '0;
                end else if (count.clear) begin
                        ast_count    <= '0;
                        shot_count   <= '0;
                        opcode_count <= '0;
                        footer_count <= '0;
                end else if (count.advance && !count.item_last) begin
                        case (count.section)
                                SEC_AST_POS:     ast_count    <= ast_count + 1'b1;
                                SEC_AST_OPCODE,
                                SEC_SHOT_OPCODE: opcode_count <= opcode_count + 1'b1;
                                SEC_SHOT_POS:    shot_count   <= shot_count + 1'b1;
                                SEC_FOOTER:      footer_count <= footer_count + 1'b1;
                                default:         ;
                        endcase
                end else if (count.advance && count.section == SEC_AST_OPCODE) begin
                        // shared opcode counter restarts for the shot opcodes
                        opcode_count <= '0;
                end
        end

        always_comb begin
                count.item_index = '0;
                count.item_last  = 1'b1;
                case (count.section)
                        SEC_AST_POS: begin
                                count.item_index = ast_count;
                                count.item_last  = (ast_count == AST_LAST);
                        end
                        SEC_AST_OPCODE, SEC_SHOT_OPCODE: begin
                                count.item_index = opcode_count;
                                count.item_last  = (opcode_count == OPCODE_LAST);
                        end
                        SEC_SHOT_POS: begin
                                count.item_index = shot_count;
                                count.item_last  = (shot_count == SHOT_LAST);
                        end
                        SEC_FOOTER: begin
                                count.item_index = footer_count;
                                count.item_last  = (footer_count == FOOTER_LAST);
                        end
                        default: ;
                endcase
        end

endmodule

// ==== src/byte_request.sv ====
`timescale 1ns/1ps

module byte_request (
        input  logic                           clock,
        input  logic                           reset,
        input  logic                           start,
        input  logic                           clear,
        input  frame_pkg::section_t            section,
        input  logic [frame_pkg::INDEX_W-1:0]  item_index,
        output logic                           tx_start,
        output frame_pkg::section_t            tx_section,
        output logic [frame_pkg::INDEX_W-1:0]  tx_index,
        output logic [frame_pkg::INDEX_W-1:0]  tx_byte_number
);
        import frame_pkg::*;

        // bytes already requested in this frame
        logic [INDEX_W-1:0] byte_count;

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        tx_start       <= 1'b0;
                        byte_count     <= '0;
                        tx_byte_number <= '0;
                end else begin
                        tx_start <= start;
                        if (clear) begin
                                byte_count     <= '0;
                                tx_byte_number <= '0;
                        end else if (start) begin
                                tx_byte_number <= byte_count;
                                byte_count     <= byte_count + 1'b1;
                        end
                end
        end

        // section and index hold until the next request
        always_ff @(posedge clock) begin
                if (start) begin
                        tx_section <= section;
                        tx_index   <= item_index;
                end
        end

endmodule

// ==== src/frame_sender.sv ====
`timescale 1ns/1ps

module frame_sender #(
        parameter int N_ASTEROIDS    = 4,
        parameter int N_SHOTS        = 3,
        parameter int N_OPCODE_BYTES = 2,
        parameter int N_FOOTER       = 2
) (
        input  logic                           clock,
        input  logic                           reset,
        input  logic                           send,
        input  logic                           tx_done,
        output logic                           tx_start,
        output frame_pkg::section_t            tx_section,
        output logic [frame_pkg::INDEX_W-1:0]  tx_index,
        output logic [frame_pkg::INDEX_W-1:0]  tx_byte_number,
        output logic                           frame_done
);

        logic start;
        logic clear;

        frame_count_if count ();

        frame_sequencer u_sequencer (
                .clock      (clock),
                .reset      (reset),
                .send       (send),
                .tx_done    (tx_done),
                .count      (count.sequencer),
                .start      (start),
                .clear      (clear),
                .frame_done (frame_done)
        );

        section_counters #(
                .N_ASTEROIDS    (N_ASTEROIDS),
                .N_SHOTS        (N_SHOTS),
                .N_OPCODE_BYTES (N_OPCODE_BYTES),
                .N_FOOTER       (N_FOOTER)
        ) u_counters (
                .clock (clock),
                .reset (reset),
                .count (count.counters)
        );

        byte_request u_request (
                .clock          (clock),
                .reset          (reset),
                .start          (start),
                .clear          (clear),
                .section        (count.section),
                .item_index     (count.item_index),
                .tx_start       (tx_start),
                .tx_section     (tx_section),
                .tx_index       (tx_index),
                .tx_byte_number (tx_byte_number)
        );

endmodule

// ==== tb/frame_sender_assertions.sv ====
`timescale 1ns/1ps

module frame_sender_assertions (
        input logic              clock,
        input logic              reset,
        input logic              tx_done,
        input logic              start,
        input logic              frame_done,
        input frame_pkg::state_t state
);
        import frame_pkg::*;

        int unsigned failures = 0;

        // a request stays outstanding until the transmitter answers
        logic in_flight;

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        in_flight <= 1'b0;
                end else if (start) begin
                        in_flight <= 1'b1;
                end else if (tx_done) begin
                        in_flight <= 1'b0;
                end
        end

        start_not_with_done: assert property (@(posedge clock) disable iff (reset)
                !(start && frame_done))
                else begin
                        failures++;
                        $error("start and frame_done high in the same cycle");
                end

        one_byte_in_flight: assert property (@(posedge clock) disable iff (reset)
                start |-> !in_flight)
                else begin
                        failures++;
                        $error("start repeated without tx_done in between");
                end

        idle_in_reset: assert property (@(posedge clock) reset |-> state == ST_IDLE)
                else begin
                        failures++;
                        $error("sequencer not idle during reset");
                end

endmodule

bind frame_sequencer frame_sender_assertions u_assertions (
        .clock      (clock),
        .reset      (reset),
        .tx_done    (tx_done),
        .start      (start),
        .frame_done (frame_done),
        .state      (state)
);

// ==== tb/tb_frame_sender.sv ====
`timescale 1ns/1ps

module tb_frame_sender;
        import frame_pkg::*;

        localparam int N_ASTEROIDS    = 4;
        localparam int N_SHOTS        = 3;
        localparam int N_OPCODE_BYTES = 2;
        localparam int N_FOOTER       = 2;
        localparam int CLOCK_PERIOD   = 20;
        localparam int MAX_DELAY      = 15;
        // score, ship and special are one byte each
        localparam int FRAME_LEN      = 3 + N_ASTEROIDS + N_SHOTS + 2 * N_OPCODE_BYTES + N_FOOTER;
        // six full frames plus the cut one, each byte at worst delay plus overhead
        localparam int TIMEOUT_CYCLES = 7 * FRAME_LEN * (MAX_DELAY + 5) + 500;

        logic               clock;
        logic               reset;
        logic               send;
        logic               tx_done;
        logic               tx_start;
        section_t           tx_section;
        logic [INDEX_W-1:0] tx_index;
        logic [INDEX_W-1:0] tx_byte_number;
        logic               frame_done;

        logic [31:0]        lcg_state;
        section_t           exp_section[$];
        logic [INDEX_W-1:0] exp_index[$];

        frame_sender #(
                .N_ASTEROIDS    (N_ASTEROIDS),
                .N_SHOTS        (N_SHOTS),
                .N_OPCODE_BYTES (N_OPCODE_BYTES),
                .N_FOOTER       (N_FOOTER)
        ) dut (
                .clock          (clock),
                .reset          (reset),
                .send           (send),
                .tx_done        (tx_done),
                .tx_start       (tx_start),
                .tx_section     (tx_section),
                .tx_index       (tx_index),
                .tx_byte_number (tx_byte_number),
                .frame_done     (frame_done)
        );

        always #(CLOCK_PERIOD / 2) clock = ~clock;

        function automatic logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        task automatic stop_with_failure(input string reason);
                $display("%s", reason);
                $display("** FAIL **");
                $fatal(1, "run stopped at first failure");
        endtask

        task automatic check_section(input string name, input section_t actual,
                                     input section_t expected);
                if (actual !== expected) begin
                        stop_with_failure($sformatf("Error at %0t: %s is %s, expected %s",
                                                    $time, name, actual.name(), expected.name()));
                end
        endtask

        task automatic check_index(input string name, input logic [INDEX_W-1:0] actual,
                                   input logic [INDEX_W-1:0] expected);
                if (actual !== expected) begin
                        stop_with_failure($sformatf("Error at %0t: %s is %0d, expected %0d",
                                                    $time, name, actual, expected));
                end
        endtask

        task automatic check_byte_number(input string name, input logic [INDEX_W-1:0] actual,
                                         input logic [INDEX_W-1:0] expected);
                if (actual !== expected) begin
                        stop_with_failure($sformatf("Error at %0t: %s is %0d, expected %0d",
                                                    $time, name, actual, expected));
                end
        endtask

        task automatic check_bit(input string name, input logic actual, input logic expected);
                if (actual !== expected) begin
                        stop_with_failure($sformatf("Error at %0t: %s is %b, expected %b",
                                                    $time, name, actual, expected));
                end
        endtask

        task automatic add_section(input section_t sec, input int count);
                for (int i = 0; i < count; i++) begin
                        exp_section.push_back(sec);
                        exp_index.push_back(INDEX_W'(i));
                end
        endtask

        task automatic build_expected();
                add_section(SEC_SCORE, 1);
                add_section(SEC_SHIP, 1);
                add_section(SEC_AST_POS, N_ASTEROIDS);
                add_section(SEC_AST_OPCODE, N_OPCODE_BYTES);
                add_section(SEC_SHOT_POS, N_SHOTS);
                add_section(SEC_SHOT_OPCODE, N_OPCODE_BYTES);
                add_section(SEC_SPECIAL, 1);
                add_section(SEC_FOOTER, N_FOOTER);
        endtask

        task automatic start_frame();
                send = 1'b1;
                @(negedge clock);
                send = 1'b0;
        endtask

        // transmitter model that answers each request and checks it against the list
        task automatic serve_frame(input bit random_delay, input bit poke_send);
                int n;
                int delay;
                n = 0;
                while (!frame_done) begin
                        @(negedge clock);
                        if (tx_start) begin
                                if (n >= int'(exp_section.size())) begin
                                        stop_with_failure(
                                                "more requests than the frame holds");
                                end
                                check_section("tx_section", tx_section, exp_section[n]);
                                check_index("tx_index", tx_index, exp_index[n]);
                                check_byte_number("tx_byte_number", tx_byte_number, INDEX_W'(n));
                                if (random_delay) begin
                                        delay = int'(lcg_next() >> 16) % (MAX_DELAY + 1);
                                end else begin
                                        delay = 1;
                                end
                                repeat (delay) begin
                                        @(negedge clock);
                                        // request must hold while the transmitter is busy
                                        check_bit("tx_start", tx_start, 1'b0);
                                        check_section("tx_section", tx_section, exp_section[n]);
                                        check_index("tx_index", tx_index, exp_index[n]);
                                        check_byte_number("tx_byte_number", tx_byte_number,
                                                          INDEX_W'(n));
                                end
                                tx_done = 1'b1;
                                send    = poke_send;
                                @(negedge clock);
                                tx_done = 1'b0;
                                send    = 1'b0;
                                n++;
                        end
                end
                if (n != int'(exp_section.size())) begin
                        stop_with_failure($sformatf("frame ended after %0d of %0d requests",
                                                    n, exp_section.size()));
                end
        endtask

        task automatic check_quiet(input int cycles);
                repeat (cycles) begin
                        @(negedge clock);
                        check_bit("tx_start", tx_start, 1'b0);
                        check_bit("frame_done", frame_done, 1'b0);
                end
        endtask

        task automatic test_single_frame();
                start_frame();
                serve_frame(1'b0, 1'b0);
                check_quiet(10);
        endtask

        task automatic test_slow_transmitter();
                start_frame();
                serve_frame(1'b1, 1'b0);
                check_quiet(10);
        endtask

        task automatic test_send_while_busy();
                start_frame();
                serve_frame(1'b0, 1'b1);
                check_quiet(10);
        endtask

        task automatic test_back_to_back();
                start_frame();
                serve_frame(1'b0, 1'b0);
                start_frame();
                serve_frame(1'b0, 1'b0);
                check_quiet(10);
        endtask

        task automatic test_reset_mid_frame();
                start_frame();
                tx_done = 1'b1;
                repeat (12) @(negedge clock);
                tx_done = 1'b0;
                if (tx_byte_number == '0) begin
                        stop_with_failure("frame did not get under way before the reset");
                end
                reset = 1'b1;
                repeat (2) begin
                        @(negedge clock);
                        check_bit("tx_start", tx_start, 1'b0);
                        check_bit("frame_done", frame_done, 1'b0);
                        check_byte_number("tx_byte_number", tx_byte_number, '0);
                end
                reset = 1'b0;
                check_quiet(3);
                check_byte_number("tx_byte_number", tx_byte_number, '0);
                start_frame();
                serve_frame(1'b0, 1'b0);
                check_quiet(10);
        endtask

        initial begin
                clock     = 1'b0;
                reset     = 1'b1;
                send      = 1'b0;
                tx_done   = 1'b0;
                lcg_state = 32'h0172_1263;
                build_expected();
                repeat (5) @(negedge clock);
                reset = 1'b0;
                check_bit("tx_start", tx_start, 1'b0);
                check_bit("frame_done", frame_done, 1'b0);
                check_byte_number("tx_byte_number", tx_byte_number, '0);

                test_single_frame();
                test_slow_transmitter();
                test_send_while_busy();
                test_back_to_back();
                test_reset_mid_frame();

                if (dut.u_sequencer.u_assertions.failures == 0) begin
                        $display("** PASS **");
                end else begin
                        $display("protocol assertions failed %0d times",
                                 dut.u_sequencer.u_assertions.failures);
                        $display("** FAIL **");
                end
                $finish;
        end

        initial begin
                #(TIMEOUT_CYCLES * CLOCK_PERIOD);
                $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("** FAIL **");
                $fatal(1, "watchdog expired");
        end

endmodule

// ==== filelist.f ====
common/frame_pkg.sv
common/frame_count_if.sv
src/frame_sequencer.sv
src/section_counters.sv
src/byte_request.sv
src/frame_sender.sv
tb/frame_sender_assertions.sv
tb/tb_frame_sender.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
LINT     = --lint-only --timing
TOP      = tb_frame_sender
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = ** PASS **
FAIL_MSG = ** FAIL **

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation stopped early"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
